// ==== list.f ====
+incdir+.
idStagePkg.sv
instrDecoder.sv
regFile.sv
operandFetch.sv
idIssue.sv
idTop.sv
idStage_properties.sv
idStage_tb.sv

// ==== Bender.yml ====
package:
  name: id_stage

sources:
  - include_dirs:
      - .
    files:
      - idStagePkg.sv
      - instrDecoder.sv
      - regFile.sv
      - operandFetch.sv
      - idIssue.sv
      - idTop.sv
  - target: test
    include_dirs:
      - .
    files:
      - idStage_properties.sv
      - idStage_tb.sv

// ==== idStage_tb.sv ====
`timescale 1ns/1ps
`include "idStage_config.svh"

module idStage_tb;
    import idStagePkg::*;

    localparam int ENC_N = 63;

    // Encoding table of symbol, format kind and selector (funct, opcode, rt or rs)
    // Kind 0 is SPECIAL, 1 I/J, 2 REGIMM, 3 SPECIAL2, 4 COP0 move and 5 ERET
    localparam logic [15:0] ENC [ENC_N] = '{
        {ADD, 3'd0, 6'h20}, {SUB, 3'd0, 6'h22}, {ADDU, 3'd0, 6'h21}, {SUBU, 3'd0, 6'h23},
        {AND, 3'd0, 6'h24}, {OR, 3'd0, 6'h25}, {XOR, 3'd0, 6'h26}, {NOR, 3'd0, 6'h27},
        {SLT, 3'd0, 6'h2A}, {SLTU, 3'd0, 6'h2B}, {SLL, 3'd0, 6'h00}, {SLLV, 3'd0, 6'h04},
        {SRL, 3'd0, 6'h02}, {SRLV, 3'd0, 6'h06}, {SRA, 3'd0, 6'h03}, {SRAV, 3'd0, 6'h07},
        {JALR, 3'd0, 6'h09}, {JR, 3'd0, 6'h08}, {MULT, 3'd0, 6'h18}, {MULTU, 3'd0, 6'h19},
        {DIV, 3'd0, 6'h1A}, {DIVU, 3'd0, 6'h1B}, {MFHI, 3'd0, 6'h10}, {MFLO, 3'd0, 6'h12},
        {MTHI, 3'd0, 6'h11}, {MTLO, 3'd0, 6'h13}, {MOVZ, 3'd0, 6'h0A}, {MOVN, 3'd0, 6'h0B},
        {ADDI, 3'd1, 6'h08}, {ADDIU, 3'd1, 6'h09}, {ANDI, 3'd1, 6'h0C}, {ORI, 3'd1, 6'h0D},
        {XORI, 3'd1, 6'h0E}, {LUI, 3'd1, 6'h0F}, {SLTI, 3'd1, 6'h0A}, {SLTIU, 3'd1, 6'h0B},
        {LW, 3'd1, 6'h23}, {LH, 3'd1, 6'h21}, {LHU, 3'd1, 6'h25}, {LB, 3'd1, 6'h20},
        {LBU, 3'd1, 6'h24}, {SW, 3'd1, 6'h2B}, {SH, 3'd1, 6'h29}, {SB, 3'd1, 6'h28},
        {BEQ, 3'd1, 6'h04}, {BNE, 3'd1, 6'h05}, {BLEZ, 3'd1, 6'h06}, {BGTZ, 3'd1, 6'h07},
        {J, 3'd1, 6'h02}, {JAL, 3'd1, 6'h03}, {BGEZ, 3'd2, 6'h01}, {BLTZ, 3'd2, 6'h00},
        {BGEZAL, 3'd2, 6'h11}, {BLTZAL, 3'd2, 6'h10}, {CLO, 3'd3, 6'h21}, {CLZ, 3'd3, 6'h20},
        {MADD, 3'd3, 6'h00}, {MADDU, 3'd3, 6'h01}, {MSUB, 3'd3, 6'h04}, {MSUBU, 3'd3, 6'h05},
        {MFC0, 3'd4, 6'h00}, {MTC0, 3'd4, 6'h04}, {ERET, 3'd5, 6'h18}
    };

    localparam instrE CMP_SYMS [10] = '{BEQ, BNE, BGEZ, BGTZ, BLEZ, BLTZ, BGEZAL, BLTZAL,
                                        MOVZ, MOVN};
    localparam instrE WB_SYMS [16] = '{JAL, JALR, BGEZAL, BLTZAL, MOVZ, MOVN, LUI, LW,
                                       LB, ADD, SLL, MFHI, ADDI, ORI, SW, BEQ};

    logic               clk;
    logic               arstN;
    logic               stall;
    logic               clr;
    logic [`DATA_W-1:0] code;
    logic [`DATA_W-1:0] pc;
    excT                excIn;
    logic [`TNEW_W-1:0] tNewIn;
    fwdT                fwdEx;
    fwdT                fwdMem;
    fwdT                wb;
    earlyT              early;
    idExT               idEx;

    logic [`DATA_W-1:0] modelRegs [`REG_N];
    fwdT                pendWb;
    earlyT              expEarly;
    idExT               expNext;
    idExT               modelIdEx;
    logic [31:0]        lfsr = 32'h5c81_2d11;
    logic               checking = 1'b0;
    int                 driveId = 0;
    int                 lastChecked = 0;
    int                 errors = 0;
    int                 errBase = 0;
    int                 checks = 0;
    int                 testCount = 0;
    string              testName = "init";

    idTop UUT (
        .clk    (clk),
        .arstN  (arstN),
        .stall  (stall),
        .clr    (clr),
        .code   (code),
        .pc     (pc),
        .excIn  (excIn),
        .tNewIn (tNewIn),
        .fwdEx  (fwdEx),
        .fwdMem (fwdMem),
        .wb     (wb),
        .early  (early),
        .idEx   (idEx)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    function automatic logic [31:0] randBits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic logic [31:0] encMask(input logic [2:0] k);
        case (k)
            3'd0, 3'd3: return 32'hFC00_003F;
            3'd1:       return 32'hFC00_0000;
            3'd2:       return 32'hFC1F_0000;
            3'd4:       return 32'hFFE0_0000;
            default:    return 32'hFFE0_003F;
        endcase
    endfunction

    function automatic logic [31:0] encVal(input logic [2:0] k, input logic [5:0] sel);
        case (k)
            3'd0:    return {26'd0, sel};
            3'd1:    return {sel, 26'd0};
            3'd2:    return {6'h01, 5'd0, sel[4:0], 16'd0};
            3'd3:    return {6'h1C, 20'd0, sel};
            3'd4:    return {6'h10, sel[4:0], 21'd0};
            default: return {6'h10, 5'h10, 15'd0, sel};
        endcase
    endfunction

    function automatic instrE refSymbol(input logic [31:0] w, output logic known);
        known = 1'b1;
        if (w == '0) begin
            return NOP;
        end
        for (int i = 0; i < ENC_N; i++) begin
            if ((w & encMask(ENC[i][8:6])) == encVal(ENC[i][8:6], ENC[i][5:0])) begin
                return instrE'(ENC[i][15:9]);
            end
        end
        known = 1'b0;
        return NOP;
    endfunction

    function automatic fieldsT refFields(input logic [31:0] w);
        fieldsT f;
        f.rs = w[25:21];
        f.rt = w[20:16];
        f.rd = w[15:11];
        f.shamt = w[10:6];
        f.imm16 = w[15:0];
        f.jmpAddr = w[25:0];
        return f;
    endfunction

    // EX beats MEM beats the register file with its write-port bypass
    function automatic logic [31:0] refOperand(input logic [4:0] a);
        if (a != 0 && fwdEx.addr == a) begin
            return fwdEx.data;
        end
        if (a != 0 && fwdMem.addr == a) begin
            return fwdMem.data;
        end
        if (a == 0) begin
            return '0;
        end
        return (wb.addr == a) ? wb.data : modelRegs[a];
    endfunction

    function automatic logic refCompare(input instrE s, input logic [31:0] a,
                                        input logic [31:0] b);
        case (s)
            BEQ:            return a == b;
            BNE:            return a != b;
            BGEZ, BGEZAL:   return $signed(a) >= 0;
            BGTZ:           return $signed(a) > 0;
            BLEZ:           return $signed(a) <= 0;
            BLTZ, BLTZAL:   return $signed(a) < 0;
            MOVZ:           return b == 0;
            MOVN:           return b != 0;
            default:        return 1'b0;
        endcase
    endfunction

    function automatic fwdT refWriteBack(input instrE s, input fieldsT f,
                                         input logic [31:0] rsD, input logic c,
                                         input logic [31:0] pcV);
        fwdT r;
        r = '0;
        case (s)
            JAL:            r.addr = 5'd31;
            BGEZAL, BLTZAL: r.addr = c ? 5'd31 : 5'd0;
            MOVZ, MOVN:     r.addr = c ? f.rd : 5'd0;
            ADD, SUB, ADDU, SUBU, AND, OR, XOR, NOR, SLT, SLTU, SLL, SLLV, SRL, SRLV,
            SRA, SRAV, JALR, MFHI, MFLO:
                r.addr = f.rd;
            ADDI, ADDIU, ANDI, ORI, XORI, LUI, SLTI, SLTIU, LW, LH, LHU, LB, LBU:
                r.addr = f.rt;
            default:        r.addr = 5'd0;
        endcase
        if (s inside {JAL, JALR, BGEZAL, BLTZAL}) begin
            r.data = pcV + 32'd8;
        end else if (r.addr != 0 && s == LUI) begin
            r.data = {f.imm16, 16'h0000};
        end else if (r.addr != 0 && s inside {MOVZ, MOVN}) begin
            r.data = rsD;
        end
        return r;
    endfunction

    function automatic int findEntry(input instrE s);
        for (int i = 0; i < ENC_N; i++) begin
            if (ENC[i][15:9] == s) begin
                return i;
            end
        end
        return 0;
    endfunction

    // Random word from a table entry with rs and rt forced where the format leaves them free
    function automatic logic [31:0] withRegs(input int idx, input logic [4:0] rs,
                                             input logic [4:0] rt, input logic pinRegs);
        logic [31:0] w;
        logic [2:0]  k;
        k = ENC[idx][8:6];
        w = (randBits(32) & ~encMask(k)) | encVal(k, ENC[idx][5:0]);
        if (pinRegs && k <= 3'd3) begin
            w[25:21] = rs;
        end
        if (pinRegs && (k == 3'd0 || k == 3'd1 || k == 3'd3)) begin
            w[20:16] = rt;
        end
        return w;
    endfunction

    function automatic fwdT randFwd(input int aBits);
        fwdT f;
        f.addr = randBits(aBits);
        f.data = randBits(32);
        return f;
    endfunction

    function automatic logic [31:0] edgeData();
        case (randBits(2))
            2'd0:    return '0;
            2'd1:    return 32'h8000_0000 | randBits(31);
            2'd2:    return randBits(31);
            default: return 32'hFFFF_FFFF;
        endcase
    endfunction

    task automatic checkVal(input string what, input logic [255:0] expV,
                            input logic [255:0] actV);
        checks++;
        if (expV !== actV) begin
            errors++;
            $display("error %s %s: expected %h actual %h", testName, what, expV, actV);
        end
    endtask

    task automatic computeExpected();
        instrE  sym;
        logic   known;
        fieldsT f;
        logic [31:0] rsD;
        logic [31:0] rtD;
        logic   c;
        fwdT    w;
        sym = refSymbol(code, known);
        f = refFields(code);
        rsD = refOperand(f.rs);
        rtD = refOperand(f.rt);
        c = refCompare(sym, rsD, rtD);
        w = refWriteBack(sym, f, rsD, c, pc);
        expEarly = '{instr: sym, cmp: c, addrRs: f.rs, addrRt: f.rt, imm16: f.imm16,
                     jmpAddr: f.jmpAddr, jmpReg: rsD};
        expNext = '{instr: sym, pc: pc, exc: known ? excIn : EXC_RI, dataRs: rsD,
                    dataRt: rtD, imm16: f.imm16, shamt: f.shamt, addrRs: f.rs,
                    addrRt: f.rt, addrRd: f.rd, regWriteAddr: w.addr,
                    regWriteData: w.data, tNew: (tNewIn == 0) ? 2'd0 : tNewIn - 2'd1};
    endtask

    task automatic applyCycle(input logic [31:0] word, input fwdT ex, input fwdT mem,
                              input fwdT w, input logic st, input logic cl);
        @(negedge clk);
        // Write from the last rising edge lands in the model now
        if (pendWb.addr != 0) begin
            modelRegs[pendWb.addr] = pendWb.data;
        end
        code = word;
        pc = {30'(randBits(30)), 2'b00};
        excIn = randBits(5);
        tNewIn = randBits(2);
        fwdEx = ex;
        fwdMem = mem;
        wb = w;
        stall = st;
        clr = cl;
        pendWb = w;
        computeExpected();
        driveId++;
    endtask

    task automatic resetDut();
        checking = 1'b0;
        @(negedge clk);
        arstN = 1'b0;
        code = '0;
        stall = 1'b0;
        clr = 1'b0;
        fwdEx = '0;
        fwdMem = '0;
        wb = '0;
        pendWb = '0;
        for (int r = 0; r < `REG_N; r++) begin
            modelRegs[r] = '0;
        end
        repeat (10) @(negedge clk);
        arstN = 1'b1;
        modelIdEx = '0;
        checkVal("idEx after reset", '0, idEx);
        computeExpected();
        checking = 1'b1;
    endtask

    task automatic startTest(input string name);
        testName = name;
        errBase = errors;
    endtask

    task automatic finishTest();
        int t;
        t = 0;
        while (lastChecked != driveId && t < 20) begin
            @(negedge clk);
            t++;
        end
        if (lastChecked != driveId) begin
            errors++;
            $display("test %s: comparison process fell behind the stimulus", testName);
        end
        testCount++;
        $display("test %-10s %0d errors", testName, errors - errBase);
    endtask

    // Early outputs checked before the edge and idEx once it has settled
    always begin
        @(posedge clk);
        if (checking) begin
            checkVal("early", expEarly, early);
            if (clr) begin
                modelIdEx = '0;
            end else if (!stall) begin
                modelIdEx = expNext;
            end
            #1;
            checkVal("idEx", modelIdEx, idEx);
            lastChecked = driveId;
        end
    end

    initial begin
        logic [31:0] word;
        fwdT ex;
        fwdT mem;
        fwdT w;
        arstN = 1'b0;
        stall = 1'b0;
        clr = 1'b0;
        code = '0;
        pc = '0;
        excIn = '0;
        tNewIn = '0;
        fwdEx = '0;
        fwdMem = '0;
        wb = '0;
        pendWb = '0;

        startTest("reset");
        resetDut();
        finishTest();

        startTest("decode");
        repeat (250) begin
            word = withRegs(randBits(6) % ENC_N, 5'd0, 5'd0, 1'b0);
            ex = randFwd(5);
            mem = randFwd(5);
            w = randFwd(5);
            applyCycle(word, ex, mem, w, 1'b0, 1'b0);
        end
        finishTest();

        startTest("exception");
        for (int i = 0; i < 60; i++) begin
            case (randBits(2))
                2'd0:    word = {6'd17 + 6'(randBits(3)), 26'(randBits(26))};
                2'd1:    word = {2'b11, 30'(randBits(30))};
                2'd2:    word = {6'd0, 20'(randBits(20)), 6'h01};
                default: word = '0;
            endcase
            applyCycle(word, '0, '0, '0, 1'b0, 1'b0);
        end
        finishTest();

        startTest("forward");
        for (int r = 1; r < 8; r++) begin
            w = '{addr: 5'(r), data: randBits(32)};
            applyCycle('0, '0, '0, w, 1'b0, 1'b0);
        end
        repeat (200) begin
            word = withRegs(findEntry(randBits(1) ? ADD : JR), randBits(2), randBits(2), 1'b1);
            ex = randFwd(2);
            mem = randFwd(2);
            w = randFwd(3);
            applyCycle(word, ex, mem, w, 1'b0, 1'b0);
        end
        finishTest();

        startTest("compare");
        repeat (200) begin
            word = withRegs(findEntry(CMP_SYMS[randBits(4) % 10]), 5'd1, 5'd2, 1'b1);
            ex = '{addr: 5'd1, data: edgeData()};
            mem = '{addr: 5'd2, data: edgeData()};
            if (randBits(2) == 0) begin
                mem.data = ex.data;
            end
            w = randFwd(5);
            applyCycle(word, ex, mem, w, 1'b0, 1'b0);
        end
        finishTest();

        startTest("writeback");
        repeat (250) begin
            word = withRegs(findEntry(WB_SYMS[randBits(4)]), randBits(2), randBits(2), 1'b1);
            ex = randFwd(2);
            mem = randFwd(2);
            w = randFwd(3);
            applyCycle(word, ex, mem, w, 1'b0, 1'b0);
        end
        finishTest();

        startTest("pipeline");
        repeat (150) begin
            word = withRegs(randBits(6) % ENC_N, 5'd0, 5'd0, 1'b0);
            w = randFwd(5);
            applyCycle(word, '0, '0, w, randBits(2) == 0, randBits(2) == 0);
        end
        word = withRegs(findEntry(JAL), 5'd0, 5'd0, 1'b0);
        applyCycle(word, '0, '0, '0, 1'b0, 1'b0);
        // Flush must win when both are raised
        applyCycle(word, '0, '0, '0, 1'b1, 1'b1);
        applyCycle(word, '0, '0, '0, 1'b0, 1'b0);
        finishTest();

        startTest("rerun reset");
        resetDut();
        finishTest();

        $display("tests %0d, checks %0d, errors %0d", testCount, checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// ==== idStage_properties.sv ====
`timescale 1ns/1ps

module issueChecks (
    input logic              clk,
    input logic              arstN,
    input logic              stall,
    input logic              clr,
    input idStagePkg::idExT  idEx
);
    import idStagePkg::*;

    // A flush leaves a bubble at the next edge
    assert property (@(posedge clk) disable iff (!arstN)
        clr |=> (idEx == '0))
        else $error("idEx not cleared after clr");

    assert property (@(posedge clk) disable iff (!arstN)
        (stall && !clr) |=> $stable(idEx))
        else $error("idEx changed while stalled");

    // Only links carry data without a destination
    assert property (@(posedge clk) disable iff (!arstN)
        ((idEx.regWriteAddr == '0) && !(idEx.instr inside {JAL, JALR, BGEZAL, BLTZAL}))
        |-> (idEx.regWriteData == '0))
        else $error("write data without a destination register");

endmodule

bind idIssue issueChecks props (
    .clk   (clk),
    .arstN (arstN),
    .stall (stall),
    .clr   (clr),
    .idEx  (idEx)
);

// ==== idTop.sv ====
`timescale 1ns/1ps
`include "idStage_config.svh"

module idTop (
    input  logic               clk,
    input  logic               arstN,
    input  logic               stall,
    input  logic               clr,
    input  logic [`DATA_W-1:0] code,
    input  logic [`DATA_W-1:0] pc,
    input  idStagePkg::excT    excIn,
    input  logic [`TNEW_W-1:0] tNewIn,
    input  idStagePkg::fwdT    fwdEx,
    input  idStagePkg::fwdT    fwdMem,
    input  idStagePkg::fwdT    wb,
    output idStagePkg::earlyT  early,
    output idStagePkg::idExT   idEx
);
    import idStagePkg::*;

    instrE    instr;
    fieldsT   fields;
    logic     excRi;
    operandsT operands;

    instrDecoder decoder (
        .code   (code),
        .instr  (instr),
        .fields (fields),
        .excRi  (excRi)
    );

    // Register read runs beside the decoder
    operandFetch fetch (
        .clk      (clk),
        .arstN    (arstN),
        .addrRs   (fields.rs),
        .addrRt   (fields.rt),
        .wb       (wb),
        .fwdEx    (fwdEx),
        .fwdMem   (fwdMem),
        .operands (operands)
    );

    idIssue issue (
        .clk      (clk),
        .arstN    (arstN),
        .stall    (stall),
        .clr      (clr),
        .instr    (instr),
        .fields   (fields),
        .operands (operands),
        .excRi    (excRi),
        .pc       (pc),
        .excIn    (excIn),
        .tNewIn   (tNewIn),
        .early    (early),
        .idEx     (idEx)
    );

endmodule

// ==== idIssue.sv ====
`timescale 1ns/1ps
`include "idStage_config.svh"

module idIssue (
    input  logic                 clk,
    input  logic                 arstN,
    input  logic                 stall,
    input  logic                 clr,
    input  idStagePkg::instrE    instr,
    input  idStagePkg::fieldsT   fields,
    input  idStagePkg::operandsT operands,
    input  logic                 excRi,
    input  logic [`DATA_W-1:0]   pc,
    input  idStagePkg::excT      excIn,
    input  logic [`TNEW_W-1:0]   tNewIn,
    output idStagePkg::earlyT    early,
    output idStagePkg::idExT     idEx
);
    import idStagePkg::*;

    localparam logic [`REG_AW-1:0] LINK_REG = `REG_AW'(31);

    logic               cmp;
    logic               isLink;
    logic [`REG_AW-1:0] wbAddr;
    logic [`DATA_W-1:0] wbData;
    idExT               nextIdEx;

    // Branch and conditional-move condition on forwarded operands
    function automatic logic compare(
        input instrE              op,
        input logic [`DATA_W-1:0] rs,
        input logic [`DATA_W-1:0] rt
    );
        case (op)
            BEQ:            return rs == rt;
            BNE:            return rs != rt;
            BGEZ, BGEZAL:   return !rs[`DATA_W-1];
            BLTZ, BLTZAL:   return rs[`DATA_W-1];
            BGTZ:           return !rs[`DATA_W-1] && (rs != '0);
            BLEZ:           return rs[`DATA_W-1] || (rs == '0);
            MOVZ:           return rt == '0;
            MOVN:           return rt != '0;
            default:        return 1'b0;
        endcase
    endfunction

    assign cmp    = compare(instr, operands.dataRs, operands.dataRt);
    assign isLink = instr inside {JAL, JALR, BGEZAL, BLTZAL};

    // Destination register
    always_comb begin
        wbAddr = '0;
        if (instr == JAL) begin
            wbAddr = LINK_REG;
        end else if (instr inside {BGEZAL, BLTZAL}) begin
            wbAddr = cmp ? LINK_REG : '0;
        end else if (instr inside {MOVZ, MOVN}) begin
            wbAddr = cmp ? fields.rd : '0;
        end else if (instr inside {ADD, SUB, ADDU, SUBU, AND, OR, XOR, NOR, SLT, SLTU,
                                   SLL, SLLV, SRL, SRLV, SRA, SRAV, JALR, MFHI, MFLO}) begin
            wbAddr = fields.rd;
        end else if (instr inside {ADDI, ADDIU, ANDI, ORI, XORI, LUI, SLTI, SLTIU,
                                   LW, LH, LHU, LB, LBU}) begin
            wbAddr = fields.rt;
        end
    end

    // Values already known at decode, everything else comes from later stages
    always_comb begin
        wbData = '0;
        if (isLink) begin
            wbData = pc + `DATA_W'(8);
        end else if (wbAddr == '0) begin
            // A write to $0 carries no data
            wbData = '0;
        end else if (instr == LUI) begin
            wbData = {fields.imm16, 16'h0000};
        end else if (instr inside {MOVZ, MOVN}) begin
            wbData = operands.dataRs;
        end
    end

    assign nextIdEx = '{
        instr:        instr,
        pc:           pc,
        exc:          excRi ? EXC_RI : excIn,
        dataRs:       operands.dataRs,
        dataRt:       operands.dataRt,
        imm16:        fields.imm16,
        shamt:        fields.shamt,
        addrRs:       fields.rs,
        addrRt:       fields.rt,
        addrRd:       fields.rd,
        regWriteAddr: wbAddr,
        regWriteData: wbData,
        tNew:         (tNewIn != '0) ? tNewIn - 1'b1 : '0
    };

    assign early = '{
        instr:   instr,
        cmp:     cmp,
        addrRs:  fields.rs,
        addrRt:  fields.rt,
        imm16:   fields.imm16,
        jmpAddr: fields.jmpAddr,
        jmpReg:  operands.dataRs
    };

    // Flush beats stall
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            idEx <= '0;
        end else if (clr) begin
            idEx <= '0;
        end else if (!stall) begin
            idEx <= nextIdEx;
        end
    end

endmodule

// ==== operandFetch.sv ====
`timescale 1ns/1ps
`include "idStage_config.svh"

module operandFetch (
    input  logic                 clk,
    input  logic                 arstN,
    input  logic [`REG_AW-1:0]   addrRs,
    input  logic [`REG_AW-1:0]   addrRt,
    input  idStagePkg::fwdT      wb,
    input  idStagePkg::fwdT      fwdEx,
    input  idStagePkg::fwdT      fwdMem,
    output idStagePkg::operandsT operands
);
    import idStagePkg::*;

    logic [`DATA_W-1:0] fileRs;
    logic [`DATA_W-1:0] fileRt;

    regFile gpr (
        .clk    (clk),
        .arstN  (arstN),
        .wb     (wb),
        .raddrA (addrRs),
        .raddrB (addrRt),
        .rdataA (fileRs),
        .rdataB (fileRt)
    );

    // Youngest producer first, a forward to $0 carries nothing
    function automatic logic [`DATA_W-1:0] forward(
        input logic [`REG_AW-1:0] addr,
        input logic [`DATA_W-1:0] fileData,
        input fwdT                ex,
        input fwdT                mem
    );
        if (ex.addr != '0 && ex.addr == addr) begin
            return ex.data;
        end
        if (mem.addr != '0 && mem.addr == addr) begin
            return mem.data;
        end
        return fileData;
    endfunction

    assign operands.dataRs = forward(addrRs, fileRs, fwdEx, fwdMem);
    assign operands.dataRt = forward(addrRt, fileRt, fwdEx, fwdMem);

endmodule

// ==== regFile.sv ====
`timescale 1ns/1ps
`include "idStage_config.svh"

module regFile (
    input  logic               clk,
    input  logic               arstN,
    input  idStagePkg::fwdT    wb,
    input  logic [`REG_AW-1:0] raddrA,
    input  logic [`REG_AW-1:0] raddrB,
    output logic [`DATA_W-1:0] rdataA,
    output logic [`DATA_W-1:0] rdataB
);
    import idStagePkg::*;

    logic [`DATA_W-1:0] regs [`REG_N];

    // Register 0 is never written, so it stays at its reset value of zero
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < `REG_N; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.addr != '0) begin
            regs[wb.addr] <= wb.data;
        end
    end

    // Same-cycle write is visible on the read port
    function automatic logic [`DATA_W-1:0] readPort(
        input logic [`REG_AW-1:0] addr,
        input logic [`DATA_W-1:0] stored,
        input fwdT                w
    );
        if (addr == '0) begin
            return '0;
        end
        if (addr == w.addr) begin
            return w.data;
        end
        return stored;
    endfunction

    assign rdataA = readPort(raddrA, regs[raddrA], wb);
    assign rdataB = readPort(raddrB, regs[raddrB], wb);

endmodule

// ==== instrDecoder.sv ====
`timescale 1ns/1ps
`include "idStage_config.svh"

module instrDecoder (
    input  logic [`DATA_W-1:0] code,
    output idStagePkg::instrE  instr,
    output idStagePkg::fieldsT fields,
    output logic               excRi
);
    import idStagePkg::*;

    localparam logic [5:0] OP_SPECIAL  = 6'b000000;
    localparam logic [5:0] OP_REGIMM   = 6'b000001;
    localparam logic [5:0] OP_COP0     = 6'b010000;
    localparam logic [5:0] OP_SPECIAL2 = 6'b011100;

    logic [5:0] opcode;
    logic [5:0] funct;
    instrE      sym;

    assign opcode = code[31:26];
    assign funct  = code[5:0];

    assign fields = '{
        rs:      code[25:21],
        rt:      code[20:16],
        rd:      code[15:11],
        shamt:   code[10:6],
        imm16:   code[15:0],
        jmpAddr: code[25:0]
    };

    // SPECIAL opcode, selected by funct
    function automatic instrE rFormat(input logic [5:0] f);
        case (f)
            6'b100000: return ADD;
            6'b100010: return SUB;
            6'b100001: return ADDU;
            6'b100011: return SUBU;
            6'b100100: return AND;
            6'b100101: return OR;
            6'b100110: return XOR;
            6'b100111: return NOR;
            6'b101010: return SLT;
            6'b101011: return SLTU;
            6'b000000: return SLL;
            6'b000100: return SLLV;
            6'b000010: return SRL;
            6'b000110: return SRLV;
            6'b000011: return SRA;
            6'b000111: return SRAV;
            6'b001001: return JALR;
            6'b001000: return JR;
            6'b011000: return MULT;
            6'b011001: return MULTU;
            6'b011010: return DIV;
            6'b011011: return DIVU;
            6'b010000: return MFHI;
            6'b010010: return MFLO;
            6'b010001: return MTHI;
            6'b010011: return MTLO;
            6'b001010: return MOVZ;
            6'b001011: return MOVN;
            default:   return NOP;
        endcase
    endfunction

    // I and J formats, selected by opcode alone
    function automatic instrE ijFormat(input logic [5:0] op);
        case (op)
            6'b001000: return ADDI;
            6'b001001: return ADDIU;
            6'b001100: return ANDI;
            6'b001101: return ORI;
            6'b001110: return XORI;
            6'b001111: return LUI;
            6'b001010: return SLTI;
            6'b001011: return SLTIU;
            6'b100011: return LW;
            6'b100001: return LH;
            6'b100101: return LHU;
            6'b100000: return LB;
            6'b100100: return LBU;
            6'b101011: return SW;
            6'b101001: return SH;
            6'b101000: return SB;
            6'b000100: return BEQ;
            6'b000101: return BNE;
            6'b000110: return BLEZ;
            6'b000111: return BGTZ;
            6'b000010: return J;
            6'b000011: return JAL;
            default:   return NOP;
        endcase
    endfunction

    // REGIMM branches live in the rt field
    function automatic instrE regImm(input logic [4:0] rt);
        case (rt)
            5'b00001: return BGEZ;
            5'b00000: return BLTZ;
            5'b10001: return BGEZAL;
            5'b10000: return BLTZAL;
            default:  return NOP;
        endcase
    endfunction

    function automatic instrE special2(input logic [5:0] f);
        case (f)
            6'b100001: return CLO;
            6'b100000: return CLZ;
            6'b000000: return MADD;
            6'b000001: return MADDU;
            6'b000100: return MSUB;
            6'b000101: return MSUBU;
            default:   return NOP;
        endcase
    endfunction

    // Moves by rs, anything else with the ERET funct returns from exception
    function automatic instrE cop0(input logic [4:0] rs, input logic [5:0] f);
        case (rs)
            5'b00000: return MFC0;
            5'b00100: return MTC0;
            default:  return (f == 6'b011000) ? ERET : NOP;
        endcase
    endfunction

    always_comb begin
        case (opcode)
            OP_SPECIAL:  sym = rFormat(funct);
            OP_REGIMM:   sym = regImm(fields.rt);
            OP_SPECIAL2: sym = special2(funct);
            OP_COP0:     sym = cop0(fields.rs, funct);
            default:     sym = ijFormat(opcode);
        endcase
    end

    // The zero word would decode as SLL, treat it as a plain bubble
    assign instr = (code == '0) ? NOP : sym;
    assign excRi = (code != '0) && (sym == NOP);

endmodule

// ==== idStagePkg.sv ====
`include "idStage_config.svh"

package idStagePkg;

    // Instruction symbols, NOP is zero so a cleared register decodes as a bubble
    typedef enum logic [6:0] {
        NOP = 7'd0,
        // R-type arithmetic and shifts
        ADD, SUB, ADDU, SUBU, AND, OR, XOR, NOR, SLT, SLTU,
        SLL, SLLV, SRL, SRLV, SRA, SRAV,
        // Register jumps
        JALR, JR,
        // Multiply and divide unit
        MULT, MULTU, DIV, DIVU, MFHI, MFLO, MTHI, MTLO,
        // Conditional moves
        MOVZ, MOVN,
        // Immediate arithmetic
        ADDI, ADDIU, ANDI, ORI, XORI, LUI, SLTI, SLTIU,
        // Loads and stores
        LW, LH, LHU, LB, LBU, SW, SH, SB,
        // Branches and jumps
        BEQ, BNE, BLEZ, BGTZ, J, JAL,
        BGEZ, BLTZ, BGEZAL, BLTZAL,
        // SPECIAL2
        CLO, CLZ, MADD, MADDU, MSUB, MSUBU,
        // Coprocessor 0
        MFC0, MTC0, ERET
    } instrE;

    typedef logic [4:0] excT;

    // Reserved instruction cause code
    localparam excT EXC_RI = 5'd10;

    typedef struct packed {
        logic [`REG_AW-1:0] rs;
        logic [`REG_AW-1:0] rt;
        logic [`REG_AW-1:0] rd;
        logic [4:0]         shamt;
        logic [15:0]        imm16;
        logic [25:0]        jmpAddr;
    } fieldsT;

    // Register write or forward from a later stage
    typedef struct packed {
        logic [`REG_AW-1:0] addr;
        logic [`DATA_W-1:0] data;
    } fwdT;

    typedef struct packed {
        logic [`DATA_W-1:0] dataRs;
        logic [`DATA_W-1:0] dataRt;
    } operandsT;

    // Seen by next-PC and hazard logic in the same cycle
    typedef struct packed {
        instrE              instr;
        logic               cmp;
        logic [`REG_AW-1:0] addrRs;
        logic [`REG_AW-1:0] addrRt;
        logic [15:0]        imm16;
        logic [25:0]        jmpAddr;
        logic [`DATA_W-1:0] jmpReg;
    } earlyT;

    typedef struct packed {
        instrE              instr;
        logic [`DATA_W-1:0] pc;
        excT                exc;
        logic [`DATA_W-1:0] dataRs;
        logic [`DATA_W-1:0] dataRt;
        logic [15:0]        imm16;
        logic [4:0]         shamt;
        logic [`REG_AW-1:0] addrRs;
        logic [`REG_AW-1:0] addrRt;
        logic [`REG_AW-1:0] addrRd;
        logic [`REG_AW-1:0] regWriteAddr;
        logic [`DATA_W-1:0] regWriteData;
        logic [`TNEW_W-1:0] tNew;
    } idExT;

endpackage

// ==== idStage_config.svh ====
`ifndef ID_STAGE_CONFIG_SVH
`define ID_STAGE_CONFIG_SVH

// Register and datapath width
`define DATA_W 32

// Register address width and register count
`define REG_AW 5
`define REG_N  32

// Width of the hazard unit's Tnew count
`define TNEW_W 2

`endif
